// File: bmd_tx_pkg.sv
// Shared widths, format codes and packed types for the bmd_tx transmit engine.
// Every module imports this package inside its body. Port types in module
// headers use package-scoped names.

package bmd_tx_pkg;

    //------------------------------
    // Widths
    //------------------------------
    localparam int DATA_W     = 64;   // Link beat
    localparam int LEN_W      = 10;   // Payload length in DW
    localparam int BUF_ADDR_W = 8;    // Position buffer depth 256
    localparam int RD_ADDR_W  = 7;    // PIO memory DW address
    localparam int CNT_W      = 16;   // Write packet counter

    //------------------------------
    // TLP format and type codes
    //------------------------------
    localparam logic [6:0] FMT_CPLD  = 7'b10_01010;  // Completion with data
    localparam logic [6:0] FMT_MWR64 = 7'b11_00000;  // 4DW header memory write

    // One link beat with framing
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              sof;
        logic              eof;
    } tlp_beat_t;

    // PIO read request fields, held stable until the completion is done
    typedef struct packed {
        logic [2:0]       tc;
        logic             td;
        logic             ep;
        logic [1:0]       attr;
        logic [LEN_W-1:0] len;
        logic [15:0]      rid;
        logic [7:0]       tag;
        logic [3:0]       be;
        logic [10:0]      addr;   // Byte address
    } cpl_req_t;

    typedef struct packed {
        logic [11:0] byte_count;
        logic [6:0]  lower_addr;
    } cpl_calc_t;

    // Write run settings, static while a run is active
    typedef struct packed {
        logic [LEN_W-1:0] len;
        logic [3:0]       fbe;
        logic [3:0]       lbe;
        logic [31:0]      addr;
        logic [7:0]       up_addr;
        logic [CNT_W-1:0] count;
        logic [2:0]       tc;
        logic             relaxed_order;
        logic             no_snoop;
    } mwr_cfg_t;

    // Per-packet header fields
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  tag;
    } mwr_hdr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CPLD_QW1,
        ST_CPLD_WAIT,
        ST_MWR_QW1,
        ST_MWR_QWN
    } tx_state_e;

endpackage

// File: cpl_byte_calc.sv
// Completion byte count and lower address from the PIO read byte enables.
// Purely combinational, feeds the CplD header fields.

`timescale 1ns/1ps

module cpl_byte_calc (
    input  logic [3:0]            be_i,
    input  logic [6:0]            addr_i,   // Low byte address bits
    output bmd_tx_pkg::cpl_calc_t calc_o
);
    import bmd_tx_pkg::*;

    logic [1:0] first_idx;

    // Byte count from the span between first and last enable
    always_comb begin
        casez (be_i)
            4'b1??1: calc_o.byte_count = 12'd4;
            4'b01?1: calc_o.byte_count = 12'd3;
            4'b1?10: calc_o.byte_count = 12'd3;
            4'b0011: calc_o.byte_count = 12'd2;
            4'b0110: calc_o.byte_count = 12'd2;
            4'b1100: calc_o.byte_count = 12'd2;
            default: calc_o.byte_count = 12'd1;   // Single byte or none
        endcase
    end

    // Index of the lowest enabled byte
    always_comb begin
        casez (be_i)
            4'b???1: first_idx = 2'd0;
            4'b??10: first_idx = 2'd1;
            4'b?100: first_idx = 2'd2;
            4'b1000: first_idx = 2'd3;
            default: first_idx = 2'd0;
        endcase
    end

    assign calc_o.lower_addr = {addr_i[6:2], first_idx};

endmodule

// File: xy_buf_reader.sv
// In-order reader for the 256-entry position buffer.
// Holds the next payload word byte-reversed; a pop consumes it and the
// following word is latched on the same edge.

`timescale 1ns/1ps

module xy_buf_reader (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              init_rst_i,
    input  logic                              pop_i,
    output logic [bmd_tx_pkg::BUF_ADDR_W-1:0] xy_buf_addr_o,
    input  logic [bmd_tx_pkg::DATA_W-1:0]     xy_buf_dat_i,
    output logic [bmd_tx_pkg::DATA_W-1:0]     payload_o
);
    import bmd_tx_pkg::*;

    logic [BUF_ADDR_W-1:0] rd_ptr_q;     // Address of the word to load next
    logic                  primed_q;     // payload_q holds a valid word
    logic                  load;
    logic [DATA_W-1:0]     dat_rev;
    logic [DATA_W-1:0]     payload_q;

    // Refill after a pop, or once after reset to prefetch word 0
    assign load = pop_i || !primed_q;

    // Next address is always on the bus so a pop can latch it at once
    assign xy_buf_addr_o = rd_ptr_q;

    assign dat_rev = {<<8{xy_buf_dat_i}};   // Byte swap toward the link

    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            rd_ptr_q <= '0;
            primed_q <= 1'b0;
        end else if (load) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;     // Wraps at 256
            primed_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            payload_q <= dat_rev;
        end
    end

    assign payload_o = payload_q;

    // Sequencer must be idle while the read position is being cleared
    a_no_pop_in_init: assert property (
        @(posedge clk) disable iff (!rst_n)
        init_rst_i |-> !pop_i
    );

endmodule

// File: mwr_dma_ctrl.sv
// Write run tracker.
// Counts sent memory-write packets and supplies the address and tag of the
// packet about to go out. Sets the done flag after the last one.

`timescale 1ns/1ps

module mwr_dma_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  init_rst_i,
    input  bmd_tx_pkg::mwr_cfg_t  cfg_i,
    input  logic                  ext_tag_en_i,
    input  logic                  pkt_sent_i,
    output bmd_tx_pkg::mwr_hdr_t  hdr_o,
    output logic                  done_o
);
    import bmd_tx_pkg::*;

    logic [CNT_W-1:0] cnt_q;        // Packets sent in this run
    logic [31:0]      prev_addr_q;  // Address of the last sent packet
    logic             done_q;
    logic [23:0]      len_bytes;
    logic [31:0]      next_addr;
    logic             last_pkt;

    //------------------------------
    // Current packet fields
    //------------------------------

    assign len_bytes = 24'({cfg_i.len, 2'b00});

    // Step only the low 24 bits, upper byte stays fixed
    assign next_addr = {prev_addr_q[31:24], prev_addr_q[23:0] + len_bytes};

    always_comb begin
        if (cnt_q == '0) begin
            hdr_o.addr = cfg_i.addr;
        end else begin
            hdr_o.addr = next_addr;
        end
    end

    // Short tags when the extended tag field is disabled
    assign hdr_o.tag = ext_tag_en_i ? cnt_q[7:0] : {3'b000, cnt_q[4:0]};

    assign last_pkt = (cnt_q == cfg_i.count - CNT_W'(1));

    //------------------------------
    // Run state
    //------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            cnt_q       <= '0;
            prev_addr_q <= '0;
            done_q      <= 1'b0;
        end else if (pkt_sent_i) begin
            prev_addr_q <= hdr_o.addr;
            if (last_pkt) begin
                cnt_q  <= '0;
                done_q <= 1'b1;         // Held until init reset
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign done_o = done_q;

endmodule

// File: tx_sequencer.sv
// Transmit FSM of the engine.
// Picks a pending completion or write in idle, builds every beat in the
// output register and moves on only when the link takes the beat.

`timescale 1ns/1ps

module tx_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          init_rst_i,
    input  logic                          req_compl_i,
    input  bmd_tx_pkg::cpl_req_t          cpl_req_i,
    input  bmd_tx_pkg::cpl_calc_t         cpl_calc_i,
    input  logic [31:0]                   rd_data_i,
    input  logic [15:0]                   completer_id_i,
    input  logic                          mwr_start_i,
    input  bmd_tx_pkg::mwr_cfg_t          mwr_cfg_i,
    input  bmd_tx_pkg::mwr_hdr_t          mwr_hdr_i,
    input  logic                          mwr_done_i,
    input  logic [bmd_tx_pkg::DATA_W-1:0] payload_i,
    output logic                          pop_o,
    output logic                          pkt_sent_o,
    output logic                          compl_done_o,
    output bmd_tx_pkg::tlp_beat_t         tx_beat_o,
    output logic                          tx_valid_o,
    input  logic                          tx_ready_i
);
    import bmd_tx_pkg::*;

    tx_state_e         state_q;
    tlp_beat_t         tx_beat_q;
    logic              tx_valid_q;
    logic              req_compl_q;
    logic              cpl_served_q;   // Request answered and not yet dropped
    logic              compl_done_q;
    logic [LEN_W-1:0]  dw_left_q;      // Payload DWs not yet loaded
    logic              xfer;
    logic              cpl_pend;
    logic              mwr_pend;
    logic [3:0]        mwr_lbe;
    logic [DATA_W-1:0] cpld_qw0;
    logic [DATA_W-1:0] cpld_qw1;
    logic [DATA_W-1:0] mwr_qw0;
    logic [DATA_W-1:0] mwr_qw1;

    assign xfer     = tx_valid_q && tx_ready_i;
    assign cpl_pend = req_compl_q && !cpl_served_q;
    assign mwr_pend = mwr_start_i && !mwr_done_i;

    //------------------------------
    // Header beats
    //------------------------------

    assign cpld_qw0 = {1'b0, FMT_CPLD, 1'b0,
                       cpl_req_i.tc, 4'b0000, cpl_req_i.td, cpl_req_i.ep,
                       cpl_req_i.attr, 2'b00, cpl_req_i.len,
                       completer_id_i, 4'b0000, cpl_calc_i.byte_count};

    assign cpld_qw1 = {cpl_req_i.rid, cpl_req_i.tag, 1'b0,
                       cpl_calc_i.lower_addr, rd_data_i};

    assign mwr_lbe = (mwr_cfg_i.len == LEN_W'(1)) ? 4'b0000 : mwr_cfg_i.lbe;

    assign mwr_qw0 = {1'b0, FMT_MWR64, 1'b0,
                      mwr_cfg_i.tc, 6'b000000, mwr_cfg_i.relaxed_order,
                      mwr_cfg_i.no_snoop, 2'b00, mwr_cfg_i.len,
                      completer_id_i, mwr_hdr_i.tag, mwr_lbe, mwr_cfg_i.fbe};

    assign mwr_qw1 = {24'h000000, mwr_cfg_i.up_addr, mwr_hdr_i.addr[31:2], 2'b00};

    //------------------------------
    // Beat FSM
    //------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n || init_rst_i) begin
            state_q      <= ST_IDLE;
            tx_beat_q    <= '0;
            tx_valid_q   <= 1'b0;
            req_compl_q  <= 1'b0;
            cpl_served_q <= 1'b0;
            compl_done_q <= 1'b0;
            dw_left_q    <= '0;
        end else begin
            req_compl_q  <= req_compl_i;
            compl_done_q <= 1'b0;
            if (!req_compl_q) begin
                cpl_served_q <= 1'b0;
            end

            case (state_q)
                ST_IDLE: begin
                    if (cpl_pend) begin                 // Completions win
                        tx_beat_q  <= '{data: cpld_qw0, sof: 1'b1, eof: 1'b0};
                        tx_valid_q <= 1'b1;
                        state_q    <= ST_CPLD_QW1;
                    end else if (mwr_pend) begin
                        tx_beat_q  <= '{data: mwr_qw0, sof: 1'b1, eof: 1'b0};
                        tx_valid_q <= 1'b1;
                        dw_left_q  <= mwr_cfg_i.len;
                        state_q    <= ST_MWR_QW1;
                    end
                end
                ST_CPLD_QW1: begin
                    if (xfer) begin
                        tx_beat_q <= '{data: cpld_qw1, sof: 1'b0, eof: 1'b1};
                        state_q   <= ST_CPLD_WAIT;
                    end
                end
                ST_CPLD_WAIT: begin
                    if (xfer) begin
                        tx_valid_q   <= 1'b0;
                        compl_done_q <= 1'b1;
                        cpl_served_q <= 1'b1;
                        state_q      <= ST_IDLE;
                    end
                end
                ST_MWR_QW1: begin
                    if (xfer) begin
                        tx_beat_q <= '{data: mwr_qw1, sof: 1'b0, eof: 1'b0};
                        state_q   <= ST_MWR_QWN;
                    end
                end
                ST_MWR_QWN: begin
                    if (xfer && tx_beat_q.eof) begin   // Last payload beat gone
                        tx_valid_q <= 1'b0;
                        state_q    <= ST_IDLE;
                    end else if (xfer) begin
                        tx_beat_q <= '{data: payload_i, sof: 1'b0,
                                       eof: (dw_left_q == LEN_W'(2))};
                        dw_left_q <= dw_left_q - LEN_W'(2);
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Strobes to the reader and the run tracker
    assign pop_o      = xfer && (state_q == ST_MWR_QWN) && !tx_beat_q.eof;
    assign pkt_sent_o = xfer && (state_q == ST_MWR_QWN) && tx_beat_q.eof;

    assign compl_done_o = compl_done_q;
    assign tx_beat_o    = tx_beat_q;
    assign tx_valid_o   = tx_valid_q;

    // Link holds beat and valid while the sink stalls
    a_stall_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tx_valid_q && !tx_ready_i && !init_rst_i) |=>
            (tx_valid_q && $stable(tx_beat_q))
    );

    // A beat that follows a non-final transfer never opens a packet
    a_sof_first_only: assert property (
        @(posedge clk) disable iff (!rst_n)
        (xfer && !tx_beat_q.eof) |=> !(tx_valid_q && tx_beat_q.sof)
    );

endmodule

// File: bmd_tx_top.sv
// Top level of the bus-master transmit engine.
// Connects byte count logic, position buffer reader, write run tracker and
// the beat FSM to the PIO, buffer and link ports.

`timescale 1ns/1ps

module bmd_tx_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              init_rst_i,
    // PIO completion
    input  logic                              req_compl_i,
    input  bmd_tx_pkg::cpl_req_t              cpl_req_i,
    output logic                              compl_done_o,
    output logic [bmd_tx_pkg::RD_ADDR_W-1:0]  rd_addr_o,
    output logic [3:0]                        rd_be_o,
    input  logic [31:0]                       rd_data_i,
    // Write run
    input  logic                              mwr_start_i,
    input  bmd_tx_pkg::mwr_cfg_t              mwr_cfg_i,
    input  logic                              cfg_ext_tag_en_i,
    input  logic [15:0]                       completer_id_i,
    output logic                              mwr_done_o,
    // Position buffer
    output logic [bmd_tx_pkg::BUF_ADDR_W-1:0] xy_buf_addr_o,
    input  logic [bmd_tx_pkg::DATA_W-1:0]     xy_buf_dat_i,
    // Link
    output bmd_tx_pkg::tlp_beat_t             tx_beat_o,
    output logic                              tx_valid_o,
    input  logic                              tx_ready_i
);
    import bmd_tx_pkg::*;

    cpl_calc_t         cpl_calc;
    mwr_hdr_t          mwr_hdr;
    logic [DATA_W-1:0] payload;
    logic              pop;
    logic              pkt_sent;

    assign rd_addr_o = cpl_req_i.addr[RD_ADDR_W+1:2];   // DW address
    assign rd_be_o   = cpl_req_i.be;

    cpl_byte_calc u_cpl_byte_calc (
        .be_i   (cpl_req_i.be),
        .addr_i (cpl_req_i.addr[6:0]),
        .calc_o (cpl_calc)
    );

    xy_buf_reader u_xy_buf_reader (
        .clk           (clk),
        .rst_n         (rst_n),
        .init_rst_i    (init_rst_i),
        .pop_i         (pop),
        .xy_buf_addr_o (xy_buf_addr_o),
        .xy_buf_dat_i  (xy_buf_dat_i),
        .payload_o     (payload)
    );

    mwr_dma_ctrl u_mwr_dma_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_rst_i   (init_rst_i),
        .cfg_i        (mwr_cfg_i),
        .ext_tag_en_i (cfg_ext_tag_en_i),
        .pkt_sent_i   (pkt_sent),
        .hdr_o        (mwr_hdr),
        .done_o       (mwr_done_o)
    );

    tx_sequencer u_tx_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .init_rst_i     (init_rst_i),
        .req_compl_i    (req_compl_i),
        .cpl_req_i      (cpl_req_i),
        .cpl_calc_i     (cpl_calc),
        .rd_data_i      (rd_data_i),
        .completer_id_i (completer_id_i),
        .mwr_start_i    (mwr_start_i),
        .mwr_cfg_i      (mwr_cfg_i),
        .mwr_hdr_i      (mwr_hdr),
        .mwr_done_i     (mwr_done_o),
        .payload_i      (payload),
        .pop_o          (pop),
        .pkt_sent_o     (pkt_sent),
        .compl_done_o   (compl_done_o),
        .tx_beat_o      (tx_beat_o),
        .tx_valid_o     (tx_valid_o),
        .tx_ready_i     (tx_ready_i)
    );

endmodule

// File: tb_bmd_tx.sv
// Testbench for the bmd_tx transmit engine.
// Applies a table of completion, write run, priority and init reset cases.
// Buffer and PIO memory are combinational models driven by the DUT addresses.

`timescale 1ns/1ps

module tb_bmd_tx;
    import bmd_tx_pkg::*;

    localparam logic [1:0]  OP_CPL       = 2'd0;
    localparam logic [1:0]  OP_SWEEP     = 2'd1;
    localparam logic [1:0]  OP_MWR       = 2'd2;
    localparam logic [1:0]  OP_PRIO      = 2'd3;
    localparam int          N_ROWS       = 7;
    localparam int          PKT_TIMEOUT  = 200;    // Cycles allowed per packet
    localparam int          QUIET_CYCLES = 40;
    localparam logic [15:0] COMPLETER_ID = 16'h01A0;

    // Op, random ready, extended tags, request, run settings
    typedef struct packed {
        logic [1:0] op;
        logic       rand_ready;
        logic       ext_tag;
        cpl_req_t   req;
        mwr_cfg_t   cfg;
    } row_t;

    // Request order is tc, td, ep, attr, len, rid, tag, be, addr
    localparam cpl_req_t REQ_A =
        '{3'd3, 1'b0, 1'b1, 2'd2, 10'd1, 16'h0105, 8'h2A, 4'hF, 11'h12C};
    localparam cpl_req_t REQ_B =
        '{3'd0, 1'b1, 1'b0, 2'd1, 10'd1, 16'h0220, 8'h07, 4'h0, 11'h000};
    // Run order is len, fbe, lbe, addr, up_addr, count, tc, relaxed order, no snoop
    localparam mwr_cfg_t CFG_A =
        '{10'd4, 4'hF, 4'hF, 32'hA5FF_FFE0, 8'h3C, 16'd3, 3'd2, 1'b1, 1'b0};
    localparam mwr_cfg_t CFG_B =
        '{10'd2, 4'hF, 4'h3, 32'h0000_1006, 8'h00, 16'd2, 3'd0, 1'b0, 1'b1};
    localparam mwr_cfg_t CFG_C =
        '{10'd6, 4'hE, 4'h7, 32'h4000_0100, 8'hF1, 16'd2, 3'd5, 1'b0, 1'b1};

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  init_rst_i;
    logic                  req_compl_i;
    cpl_req_t              cpl_req_i;
    logic                  compl_done_o;
    logic [RD_ADDR_W-1:0]  rd_addr_o;
    logic [3:0]            rd_be_o;
    logic [31:0]           rd_data_i;
    logic                  mwr_start_i;
    mwr_cfg_t              mwr_cfg_i;
    logic                  cfg_ext_tag_en_i;
    logic [15:0]           completer_id_i;
    logic                  mwr_done_o;
    logic [BUF_ADDR_W-1:0] xy_buf_addr_o;
    logic [DATA_W-1:0]     xy_buf_dat_i;
    tlp_beat_t             tx_beat_o;
    logic                  tx_valid_o;
    logic                  tx_ready_i = 1'b1;

    row_t      rows [N_ROWS];
    string     names [N_ROWS];
    tlp_beat_t got_q [$];
    tlp_beat_t exp_q [$];
    int        seed = 2;
    int        rnd_val;
    logic      rand_ready = 1'b0;
    int        next_word;            // Payload words sent since the last init reset
    int        errors = 0;
    int        timeouts = 0;
    int        n_checks = 0;

    bmd_tx_top u_bmd_tx_top (.*);

    always #4 clk = ~clk;            // 8 ns period

    // Ready is random in stall rows and held high otherwise
    always @(posedge clk) begin
        rnd_val = $random(seed);
        tx_ready_i <= rand_ready ? rnd_val[0] : 1'b1;
    end

    // -----------------------------
    // Memory models
    // -----------------------------

    function automatic logic [63:0] buf_word(input logic [7:0] a);
        return {a, 8'hA5, ~a, 8'h3C, a ^ 8'h5A, 8'h96, a + 8'd7, 8'hC3};
    endfunction

    function automatic logic [31:0] mem_word(input logic [6:0] a);
        return {8'hDA, 1'b0, a, 1'b1, ~a, 8'h5E};
    endfunction

    assign xy_buf_dat_i = buf_word(xy_buf_addr_o);
    assign rd_data_i    = mem_word(rd_addr_o);

    // -----------------------------
    // Expected values
    // -----------------------------

    function automatic logic [63:0] byte_swap(input logic [63:0] w);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = w[8*(7-i) +: 8];
        end
        return r;
    endfunction

    function automatic tlp_beat_t mk_beat(input logic [63:0] d, input logic sof,
                                          input logic eof);
        tlp_beat_t b;
        b.data = d;
        b.sof  = sof;
        b.eof  = eof;
        return b;
    endfunction

    // Span from lowest to highest enabled byte or 1 when none is set
    function automatic cpl_calc_t ref_calc(input logic [3:0] be, input logic [10:0] addr);
        cpl_calc_t c;
        int        lo;
        int        hi;
        lo = -1;
        hi = -1;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                if (lo < 0) lo = i;
                hi = i;
            end
        end
        c.byte_count = (lo < 0) ? 12'd1 : 12'(hi - lo + 1);
        c.lower_addr = {addr[6:2], (lo < 0) ? 2'd0 : 2'(lo)};
        return c;
    endfunction

    task automatic expect_cpl(input cpl_req_t req);
        cpl_calc_t   c;
        logic [63:0] d;
        c = ref_calc(req.be, req.addr);
        d = '0;
        d[62:56] = FMT_CPLD;
        d[54:52] = req.tc;
        d[47]    = req.td;
        d[46]    = req.ep;
        d[45:44] = req.attr;
        d[41:32] = req.len;
        d[31:16] = COMPLETER_ID;
        d[11:0]  = c.byte_count;
        exp_q.push_back(mk_beat(d, 1'b1, 1'b0));
        d = '0;
        d[63:48] = req.rid;
        d[47:40] = req.tag;
        d[38:32] = c.lower_addr;
        d[31:0]  = mem_word(req.addr[8:2]);  // DW address of the read
        exp_q.push_back(mk_beat(d, 1'b0, 1'b1));
    endtask

    task automatic expect_mwr(input mwr_cfg_t cfg, input logic ext, input int pkt);
        logic [63:0] d;
        logic [23:0] low;
        int          n_beats;
        low     = cfg.addr[23:0] + 24'(pkt * int'(cfg.len) * 4);  // Top byte never steps
        n_beats = int'(cfg.len) / 2;
        d = '0;
        d[62:56] = FMT_MWR64;
        d[54:52] = cfg.tc;
        d[45]    = cfg.relaxed_order;
        d[44]    = cfg.no_snoop;
        d[41:32] = cfg.len;
        d[31:16] = COMPLETER_ID;
        d[15:8]  = ext ? 8'(pkt) : {3'b000, 5'(pkt)};
        d[7:4]   = (cfg.len == 10'd1) ? 4'h0 : cfg.lbe;
        d[3:0]   = cfg.fbe;
        exp_q.push_back(mk_beat(d, 1'b1, 1'b0));
        d = '0;
        d[39:32] = cfg.up_addr;
        d[31:0]  = {cfg.addr[31:24], low[23:2], 2'b00};
        exp_q.push_back(mk_beat(d, 1'b0, 1'b0));
        for (int b = 0; b < n_beats; b++) begin
            d = byte_swap(buf_word(8'(next_word)));   // Buffer wraps at 256
            exp_q.push_back(mk_beat(d, 1'b0, b == n_beats - 1));
            next_word++;
        end
    endtask

    // -----------------------------
    // Checks
    // -----------------------------

    task automatic check_beat(input string name, input tlp_beat_t exp_v, input tlp_beat_t act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp_v, act_v);
        end
    endtask

    task automatic check_calc(input string name, input cpl_calc_t exp_v, input cpl_calc_t act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("[FAIL] %s calc: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_be(input string name, input logic [3:0] exp_v, input logic [3:0] act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic compare_packet(input string name);
        if (got_q.size() != exp_q.size()) begin
            errors++;
            $display("%s: packet has %0d beats where %0d were expected",
                     name, got_q.size(), exp_q.size());
        end else begin
            foreach (got_q[i]) begin
                check_beat($sformatf("%s beat %0d", name, i), exp_q[i], got_q[i]);
            end
        end
    endtask

    // Beats seen at the falling edge with valid and ready both high transfer next edge
    task automatic collect_packet(input string name, output bit ok);
        int waited;
        bit seen_eof;
        waited   = 0;
        seen_eof = 1'b0;
        got_q.delete();
        while (!seen_eof && waited < PKT_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (tx_valid_o && tx_ready_i) begin
                got_q.push_back(tx_beat_o);
                seen_eof = tx_beat_o.eof;
            end
        end
        if (!seen_eof) begin
            timeouts++;
            $display("%s: no complete packet within %0d cycles", name, PKT_TIMEOUT);
        end
        ok = seen_eof;
    endtask

    // -----------------------------
    // Operations
    // -----------------------------

    task automatic finish_cpl(input string name);
        @(negedge clk);
        check_flag({name, " compl_done"}, 1'b1, compl_done_o);
        @(posedge clk);
        req_compl_i <= 1'b0;
    endtask

    task automatic run_cpl(input string name, input cpl_req_t req);
        bit        ok;
        cpl_calc_t act;
        @(posedge clk);
        cpl_req_i   <= req;
        req_compl_i <= 1'b1;
        exp_q.delete();
        expect_cpl(req);
        collect_packet(name, ok);
        check_be({name, " rd_be"}, req.be, rd_be_o);
        if (ok) begin
            compare_packet(name);
        end
        if (ok && got_q.size() == 2) begin
            act.byte_count = got_q[0].data[11:0];
            act.lower_addr = got_q[1].data[38:32];
            check_calc(name, ref_calc(req.be, req.addr), act);
        end
        finish_cpl(name);
        @(negedge clk);
        check_flag({name, " compl_done pulse"}, 1'b0, compl_done_o);
    endtask

    task automatic run_sweep(input string name, input cpl_req_t base);
        cpl_req_t    r;
        logic [10:0] addrs [3];
        addrs[0] = 11'h004;
        addrs[1] = 11'h1F9;
        addrs[2] = 11'h36E;
        for (int a = 0; a < 3; a++) begin
            for (int b = 0; b < 16; b++) begin
                r      = base;
                r.be   = 4'(b);
                r.addr = addrs[a];
                run_cpl($sformatf("%s be=%h addr=%h", name, r.be, r.addr), r);
            end
        end
    endtask

    task automatic init_pulse(input string name);
        @(posedge clk);
        init_rst_i <= 1'b1;
        @(posedge clk);
        init_rst_i <= 1'b0;
        @(negedge clk);
        check_flag({name, " mwr_done cleared"}, 1'b0, mwr_done_o);
        next_word = 0;
    endtask

    task automatic collect_run(input string name, input mwr_cfg_t cfg, input logic ext);
        bit    ok;
        string pkt_name;
        ok = 1'b1;
        for (int p = 0; p < int'(cfg.count) && ok; p++) begin
            pkt_name = $sformatf("%s pkt %0d", name, p);
            exp_q.delete();
            expect_mwr(cfg, ext, p);
            collect_packet(pkt_name, ok);
            if (ok) begin
                compare_packet(pkt_name);
            end
        end
    endtask

    // Done must be up and no further packet may start
    task automatic end_run(input string name);
        bit started;
        started = 1'b0;
        @(negedge clk);
        check_flag({name, " mwr_done"}, 1'b1, mwr_done_o);
        for (int i = 0; i < QUIET_CYCLES && !started; i++) begin
            @(negedge clk);
            started = tx_valid_o;
        end
        if (started) begin
            errors++;
            $display("%s: a write packet started after the run was done", name);
        end
        @(posedge clk);
        mwr_start_i <= 1'b0;
    endtask

    task automatic run_mwr(input string name, input mwr_cfg_t cfg, input logic ext);
        init_pulse(name);
        @(posedge clk);
        mwr_cfg_i        <= cfg;
        cfg_ext_tag_en_i <= ext;
        mwr_start_i      <= 1'b1;
        collect_run(name, cfg, ext);
        end_run(name);
    endtask

    task automatic run_prio(input string name, input cpl_req_t req, input mwr_cfg_t cfg,
                            input logic ext);
        bit ok;
        init_pulse(name);
        @(posedge clk);
        mwr_cfg_i        <= cfg;
        cfg_ext_tag_en_i <= ext;
        cpl_req_i        <= req;
        req_compl_i      <= 1'b1;
        @(posedge clk);
        mwr_start_i <= 1'b1;   // Request is registered inside, so both pend together
        exp_q.delete();
        expect_cpl(req);
        collect_packet({name, " cpl"}, ok);
        if (ok) begin
            compare_packet({name, " cpl"});
        end
        finish_cpl(name);
        collect_run(name, cfg, ext);
        end_run(name);
    endtask

    // -----------------------------
    // Stimulus table and main flow
    // -----------------------------

    initial begin
        rst_n            = 1'b0;
        init_rst_i       = 1'b0;
        req_compl_i      = 1'b0;
        cpl_req_i        = '0;
        mwr_start_i      = 1'b0;
        mwr_cfg_i        = '0;
        cfg_ext_tag_en_i = 1'b0;
        completer_id_i   = COMPLETER_ID;
        next_word        = 0;

        names[0] = "cpl_single";
        rows[0]  = '{OP_CPL, 1'b0, 1'b1, REQ_A, CFG_A};
        names[1] = "be_sweep";
        rows[1]  = '{OP_SWEEP, 1'b0, 1'b1, REQ_B, CFG_A};
        names[2] = "mwr_run";
        rows[2]  = '{OP_MWR, 1'b0, 1'b1, REQ_A, CFG_A};
        names[3] = "cpl_stall";
        rows[3]  = '{OP_CPL, 1'b1, 1'b1, REQ_A, CFG_A};
        names[4] = "mwr_stall";
        rows[4]  = '{OP_MWR, 1'b1, 1'b1, REQ_A, CFG_A};
        names[5] = "priority";
        rows[5]  = '{OP_PRIO, 1'b0, 1'b1, REQ_B, CFG_B};
        names[6] = "init_rerun";   // Short tags and a restart after init reset
        rows[6]  = '{OP_MWR, 1'b0, 1'b0, REQ_A, CFG_C};

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        for (int i = 0; i < N_ROWS; i++) begin
            @(negedge clk);
            rand_ready = rows[i].rand_ready;
            case (rows[i].op)
                OP_CPL:   run_cpl(names[i], rows[i].req);
                OP_SWEEP: run_sweep(names[i], rows[i].req);
                OP_MWR:   run_mwr(names[i], rows[i].cfg, rows[i].ext_tag);
                default:  run_prio(names[i], rows[i].req, rows[i].cfg, rows[i].ext_tag);
            endcase
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", n_checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: bmd_tx.f
bmd_tx_pkg.sv
cpl_byte_calc.sv
xy_buf_reader.sv
mwr_dma_ctrl.sv
tx_sequencer.sv
bmd_tx_top.sv
tb_bmd_tx.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_bmd_tx
FILELIST = bmd_tx.f
OBJ_DIR  = obj_dir
PASS_MSG = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
